//--- riscv_pkg.sv
// shared types and constants for the rv32i core, imported by every rtl file
package riscv_pkg;

  // data words, addresses and register indices
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  be_t;        // one bit per byte lane

  // major opcodes that the core executes
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  localparam word_t INSTR_STEP = 32'd4;  // no branches, pc only walks forward

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXECUTE,
    S_MEM_REQ,
    S_MEM_WAIT
  } ctrl_state_e;

endpackage

//--- riscv_fetch.sv
// fetch unit, keeps the pc and runs the instruction req/grant/rvalid port per start pulse
module riscv_fetch import riscv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  word_t boot_addr_i,
  input  logic  fetch_start_i,   // one-cycle pulse from the controller
  input  logic  instr_grant_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  output logic  instr_req_o,
  output word_t instr_addr_o,
  output word_t instr_o,         // held until the next fetch returns
  output logic  instr_valid_o
);

  word_t pc_q;
  word_t instr_q;
  logic  req_q;     // request out, waiting for grant
  logic  wait_q;    // granted, waiting for rvalid
  logic  valid_q;
  logic  arrive;

  assign arrive = wait_q & instr_rvalid_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_q    <= boot_addr_i;
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= arrive;  // pulse one cycle after rvalid
      if (fetch_start_i)
        req_q <= 1'b1;
      else if (req_q && instr_grant_i)
        req_q <= 1'b0;    // request ends on the grant cycle
      if (req_q && instr_grant_i)
        wait_q <= 1'b1;
      else if (instr_rvalid_i)
        wait_q <= 1'b0;
      if (arrive)
        pc_q <= pc_q + INSTR_STEP;
    end
  end

  // fetched word, decoder reads it until the next arrival
  always_ff @(posedge clk)
  begin
    if (arrive)
      instr_q <= instr_rdata_i;
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = pc_q;   // pc moves only on arrival, so stable under request
  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;

  // address must hold while the request waits for its grant
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_grant_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

//--- riscv_decoder.sv
// instruction decoder, turns the held instruction word into alu, register and memory controls
module riscv_decoder import riscv_pkg::*;
(
  input  word_t     instr_i,
  output alu_op_e   alu_op_o,
  output logic      use_imm_o,       // operand b from immediate
  output word_t     imm_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output logic      reg_we_o,
  output logic      mem_en_o,
  output logic      mem_we_o,
  output mem_size_e mem_size_o,
  output logic      mem_unsigned_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////
  // opcode and funct mapping, unknown -> nop
  //////////////////////////////////////////////////
  always_comb
  begin
    alu_op_o       = ALU_ADD;
    use_imm_o      = 1'b0;
    imm_o          = imm_i;
    reg_we_o       = 1'b0;
    mem_en_o       = 1'b0;
    mem_we_o       = 1'b0;
    mem_size_o     = SIZE_WORD;
    mem_unsigned_o = 1'b0;
    case (opcode)
      OPC_LUI:
      begin
        alu_op_o  = ALU_PASS_B;
        use_imm_o = 1'b1;
        imm_o     = imm_u;
        reg_we_o  = 1'b1;
      end
      OPC_OPIMM:
      begin
        use_imm_o = 1'b1;
        reg_we_o  = 1'b1;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001:
          begin
            alu_op_o = ALU_SLL;
            reg_we_o = (funct7 == 7'b0000000);  // slli only
          end
          default:
          begin
            alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
            reg_we_o = ((funct7 & 7'b1011111) == 7'b0000000);
          end
        endcase
      end
      OPC_OP:
      begin
        // only funct7 0 or sub/sra form is legal
        reg_we_o = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000:  alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op_o = ALU_SLL;
          3'b010:  alu_op_o = ALU_SLT;
          3'b011:  alu_op_o = ALU_SLTU;
          3'b100:  alu_op_o = ALU_XOR;
          3'b101:  alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op_o = ALU_OR;
          default: alu_op_o = ALU_AND;
        endcase
      end
      OPC_LOAD:
      begin
        use_imm_o      = 1'b1;         // addr = rs1 + imm_i
        mem_en_o       = 1'b1;
        reg_we_o       = 1'b1;
        mem_unsigned_o = funct3[2];
        case (funct3)
          3'b000, 3'b100: mem_size_o = SIZE_BYTE;
          3'b001, 3'b101: mem_size_o = SIZE_HALF;
          3'b010:         mem_size_o = SIZE_WORD;
          default:
          begin
            mem_en_o = 1'b0;
            reg_we_o = 1'b0;
          end
        endcase
      end
      OPC_STORE:
      begin
        use_imm_o = 1'b1;
        imm_o     = imm_s;
        mem_en_o  = 1'b1;
        mem_we_o  = 1'b1;
        case (funct3)
          3'b000:  mem_size_o = SIZE_BYTE;
          3'b001:  mem_size_o = SIZE_HALF;
          3'b010:  mem_size_o = SIZE_WORD;
          default:
          begin
            mem_en_o = 1'b0;
            mem_we_o = 1'b0;
          end
        endcase
      end
      default: ;  // everything else is a nop
    endcase
  end

endmodule

//--- riscv_regfile.sv
// general purpose register file, two async read ports and one clocked write port, x0 reads zero
module riscv_regfile import riscv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  logic      we_i,
  input  word_t     wdata_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  word_t regs_q [31:1];   // x1..x31, no storage for x0

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && waddr_i != '0)  // x0 writes dropped
      regs_q[waddr_i] <= wdata_i;
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- riscv_alu.sv
// integer alu, combinational, its adder result doubles as the load/store address
module riscv_alu import riscv_pkg::*;
(
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o
);

  word_t      b_inv;
  word_t      sum;
  logic       is_sub;
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign is_sub = (op_i == ALU_SUB);
  assign b_inv  = is_sub ? ~b_i : b_i;
  assign sum    = a_i + b_inv + {31'b0, is_sub};  // two's complement subtract
  assign shamt  = b_i[4:0];                       // only low five bits count
  assign lt_s   = $signed(a_i) < $signed(b_i);
  assign lt_u   = a_i < b_i;

  always_comb
  begin
    case (op_i)
      ALU_ADD, ALU_SUB: result_o = sum;
      ALU_SLL:          result_o = a_i << shamt;
      ALU_SLT:          result_o = {31'b0, lt_s};
      ALU_SLTU:         result_o = {31'b0, lt_u};
      ALU_XOR:          result_o = a_i ^ b_i;
      ALU_SRL:          result_o = a_i >> shamt;
      ALU_SRA:          result_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:           result_o = a_i | b_i;
      ALU_AND:          result_o = a_i & b_i;
      default:          result_o = b_i;   // pass_b for lui
    endcase
  end

endmodule

//--- riscv_controller.sv
// control fsm, sequences fetch, execute and data access one instruction at a time
module riscv_controller import riscv_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_enable_i,
  input  logic instr_valid_i,   // fetched word is in the decoder
  input  logic mem_en_i,
  input  logic mem_we_i,
  input  logic reg_we_i,
  input  logic mem_done_i,
  output logic fetch_start_o,
  output logic mem_start_o,
  output logic rf_we_o,
  output logic rf_sel_load_o,   // write back from lsu instead of alu
  output logic core_busy_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_comb
  begin
    state_d       = state_q;
    fetch_start_o = 1'b0;
    mem_start_o   = 1'b0;
    rf_we_o       = 1'b0;
    rf_sel_load_o = 1'b0;
    case (state_q)
      S_IDLE:
        if (fetch_enable_i)
          state_d = S_FETCH;
      S_FETCH:
      begin
        fetch_start_o = 1'b1;     // first fetch after idle
        state_d       = S_EXECUTE;
      end
      S_EXECUTE:
        // decode and alu settle in the instr_valid cycle
        if (instr_valid_i)
        begin
          if (mem_en_i)
          begin
            mem_start_o = 1'b1;
            state_d     = S_MEM_REQ;
          end
          else
          begin
            rf_we_o = reg_we_i;   // alu result, nops write nothing
            if (fetch_enable_i)
              fetch_start_o = 1'b1;  // overlap next fetch start with write back
            else
              state_d = S_IDLE;
          end
        end
      S_MEM_REQ:
        state_d = S_MEM_WAIT;     // lsu request goes out here
      S_MEM_WAIT:
      begin
        rf_sel_load_o = 1'b1;
        if (mem_done_i)
        begin
          rf_we_o = reg_we_i & ~mem_we_i;  // loads only
          if (fetch_enable_i)
          begin
            fetch_start_o = 1'b1;
            state_d       = S_EXECUTE;
          end
          else
            state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  assign core_busy_o = (state_q != S_IDLE);

endmodule

//--- riscv_lsu.sv
// load/store unit, drives the data port with word address and byte enables, aligns loads
module riscv_lsu import riscv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,      // one-cycle pulse from the controller
  input  logic      we_i,
  input  mem_size_e size_i,
  input  logic      unsigned_i,
  input  word_t     addr_i,       // byte address from the alu adder
  input  word_t     wdata_i,
  input  logic      data_gnt_i,
  input  logic      data_r_valid_i,
  input  word_t     data_rdata_i,
  output logic      data_req_o,
  output word_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output word_t     data_wdata_o,
  output word_t     rdata_o,      // aligned and extended load value
  output logic      done_o
);

  logic       req_q;
  logic       wait_q;
  logic       done_q;
  logic       we_q;
  word_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;
  be_t        be_q;
  mem_size_e  size_q;
  logic       unsigned_q;
  logic [1:0] off_q;
  be_t        be_d;
  word_t      wdata_d;
  word_t      shifted;

  //////////////////////////////////////////////////
  // store side: lanes and byte enables
  //////////////////////////////////////////////////
  always_comb
  begin
    case (size_i)
      SIZE_BYTE:
      begin
        be_d    = be_t'(4'b0001 << addr_i[1:0]);
        wdata_d = {4{wdata_i[7:0]}};   // copy into every lane
      end
      SIZE_HALF:
      begin
        be_d    = addr_i[1] ? 4'b1100 : 4'b0011;  // bit 0 ignored
        wdata_d = {2{wdata_i[15:0]}};
      end
      default:
      begin
        be_d    = 4'b1111;
        wdata_d = wdata_i;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      done_q <= 1'b0;
      we_q   <= 1'b0;
    end
    else
    begin
      done_q <= wait_q & data_r_valid_i;  // stores wait for rvalid too
      if (start_i)
      begin
        req_q <= 1'b1;
        we_q  <= we_i;
      end
      else if (req_q && data_gnt_i)
        req_q <= 1'b0;
      if (req_q && data_gnt_i)
        wait_q <= 1'b1;
      else if (data_r_valid_i)
        wait_q <= 1'b0;
    end
  end

  // access payload, loaded on start
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      addr_q     <= {addr_i[31:2], 2'b00};
      off_q      <= addr_i[1:0];
      be_q       <= be_d;
      wdata_q    <= wdata_d;
      size_q     <= size_i;
      unsigned_q <= unsigned_i;
    end
    if (wait_q && data_r_valid_i)
      rdata_q <= data_rdata_i;     // raw word, aligned below
  end

  //////////////////////////////////////////////////
  // load side: shift lane down and extend
  //////////////////////////////////////////////////
  always_comb
  begin
    shifted = rdata_q >> {off_q, 3'b000};
    case (size_q)
      SIZE_BYTE: rdata_o = {{24{shifted[7] & ~unsigned_q}}, shifted[7:0]};
      SIZE_HALF:
      begin
        shifted = rdata_q >> {off_q[1], 4'b0000};
        rdata_o = {{16{shifted[15] & ~unsigned_q}}, shifted[15:0]};
      end
      default:   rdata_o = rdata_q;
    endcase
  end

  assign data_req_o   = req_q;
  assign data_addr_o  = addr_q;
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_wdata_o = wdata_q;
  assign done_o       = done_q;

  // at least one lane per request, and the enables hold until granted
  a_be_nonzero : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> (|data_be_o));
  a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_be_o) && $stable(data_addr_o));

endmodule

//--- riscv_core.sv
// top level of the multi-cycle rv32i core, external memory ports and block wiring
module riscv_core import riscv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  word_t boot_addr_i,
  input  logic  fetch_enable_i,
  // instruction port
  output word_t instr_addr_o,
  output logic  instr_req_o,
  input  word_t instr_rdata_i,
  input  logic  instr_grant_i,
  input  logic  instr_rvalid_i,
  // data port
  output word_t data_addr_o,
  output word_t data_wdata_o,
  output logic  data_we_o,
  output logic  data_req_o,
  output be_t   data_be_o,
  input  word_t data_rdata_i,
  input  logic  data_gnt_i,
  input  logic  data_r_valid_i,
  output logic  core_busy_o
);

  word_t     instr;
  logic      instr_valid;
  logic      fetch_start;
  logic      mem_start;
  logic      mem_done;
  alu_op_e   alu_op;
  logic      use_imm;
  word_t     imm;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      dec_reg_we;
  logic      mem_en;
  logic      mem_we;
  mem_size_e mem_size;
  logic      mem_unsigned;
  logic      rf_we;
  logic      rf_sel_load;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     alu_result;
  word_t     load_data;
  word_t     rf_wdata;

  //////////////////////////////////////////////////
  // operand and write back selects
  //////////////////////////////////////////////////
  assign alu_b    = use_imm ? imm : rs2_data;
  assign rf_wdata = rf_sel_load ? load_data : alu_result;

  riscv_fetch fetch_i (
    .clk, .rst_n, .boot_addr_i,
    .fetch_start_i (fetch_start),
    .instr_grant_i, .instr_rvalid_i, .instr_rdata_i,
    .instr_req_o, .instr_addr_o,
    .instr_o       (instr),
    .instr_valid_o (instr_valid)
  );

  riscv_decoder decoder_i (
    .instr_i        (instr),
    .alu_op_o       (alu_op),
    .use_imm_o      (use_imm),
    .imm_o          (imm),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rd_o           (rd),
    .reg_we_o       (dec_reg_we),
    .mem_en_o       (mem_en),
    .mem_we_o       (mem_we),
    .mem_size_o     (mem_size),
    .mem_unsigned_o (mem_unsigned)
  );

  riscv_regfile regfile_i (
    .clk, .rst_n,
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  riscv_alu alu_i (
    .op_i     (alu_op),
    .a_i      (rs1_data),
    .b_i      (alu_b),
    .result_o (alu_result)   // also the memory address
  );

  riscv_controller controller_i (
    .clk, .rst_n, .fetch_enable_i,
    .instr_valid_i (instr_valid),
    .mem_en_i      (mem_en),
    .mem_we_i      (mem_we),
    .reg_we_i      (dec_reg_we),
    .mem_done_i    (mem_done),
    .fetch_start_o (fetch_start),
    .mem_start_o   (mem_start),
    .rf_we_o       (rf_we),
    .rf_sel_load_o (rf_sel_load),
    .core_busy_o
  );

  riscv_lsu lsu_i (
    .clk, .rst_n,
    .start_i    (mem_start),
    .we_i       (mem_we),
    .size_i     (mem_size),
    .unsigned_i (mem_unsigned),
    .addr_i     (alu_result),
    .wdata_i    (rs2_data),   // store data straight from rs2
    .data_gnt_i, .data_r_valid_i, .data_rdata_i,
    .data_req_o, .data_addr_o, .data_we_o, .data_be_o, .data_wdata_o,
    .rdata_o    (load_data),
    .done_o     (mem_done)
  );

endmodule

//--- tb_riscv_core.sv
// self-checking testbench that runs a random program on the rv32i core against an isa model
module tb_riscv_core import riscv_pkg::*;
();

  localparam word_t BOOT_ADDR  = 32'h0000_0400;
  localparam int    CLK_HALF   = 10;
  localparam int    DRIVE_DLY  = 2;    // inputs change this long after the rising edge
  localparam int    N_KEPT     = 300;
  localparam int    CYC_BUDGET = 40;   // cycles allowed per instruction

  logic  clk;
  logic  rst_n;
  logic  fetch_enable_i;
  word_t boot_addr_i;
  word_t instr_addr_o;
  logic  instr_req_o;
  word_t instr_rdata_i;
  logic  instr_grant_i;
  logic  instr_rvalid_i;
  word_t data_addr_o;
  word_t data_wdata_o;
  logic  data_we_o;
  logic  data_req_o;
  be_t   data_be_o;
  word_t data_rdata_i;
  logic  data_gnt_i;
  logic  data_r_valid_i;
  logic  core_busy_o;

  word_t imem [word_t];   // program by byte address
  word_t dmem [word_t];   // data words by word address
  word_t regs [32];       // model register file
  word_t model_pc;
  word_t end_addr;
  word_t rng_state;
  word_t gen_addr;
  int    prog_len;
  int    n_unknown;
  int    cycle_cnt = 0;
  int    last_valid_cyc;  // cycle of the last rvalid on either port
  logic  acc_pending;     // model expects a data access
  logic  acc_we;
  word_t acc_addr;
  be_t   acc_be;
  word_t acc_wdata;

  riscv_core uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // reporting and compares
  //////////////////////////////////////////////////
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
      stop_run($sformatf("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_be(input string what, input be_t got, input be_t exp);
    if (got !== exp)
      stop_run($sformatf("Fail at time %0t: %s are %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // every request rises two cycles after the previous rvalid
  task automatic request_spacing(input string what);
    if (cycle_cnt != last_valid_cyc + 2)
      stop_run($sformatf("Fail at time %0t: %s rose %0d cycles after the last valid, expected 2",
                         $time, what, cycle_cnt - last_valid_cyc));
  endtask

  //////////////////////////////////////////////////
  // random numbers and memory fill
  //////////////////////////////////////////////////
  function automatic word_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 8) % word_t'(n));  // low lcg bits are weak
  endfunction

  function automatic reg_addr_t pick_reg();
    return reg_addr_t'(rand_below(32));
  endfunction

  function automatic word_t fill_word(input word_t a);
    return (a ^ 32'h5bd1_e995) * 32'h0019_660d + {a[15:0], a[31:16]};
  endfunction

  function automatic word_t dmem_read(input word_t a);
    return dmem.exists(a) ? dmem[a] : fill_word(a);
  endfunction

  //////////////////////////////////////////////////
  // program generation
  //////////////////////////////////////////////////
  task automatic emit(input word_t ins);
    imem[gen_addr] = ins;
    gen_addr       = gen_addr + 4;
    prog_len++;
  endtask

  // sw of one register so its value shows on the data port
  task automatic emit_observe(input reg_addr_t src);
    word_t r;
    r = next_rand();
    emit({r[11:5], src, pick_reg(), 3'd2, r[4:0], OPC_STORE});
  endtask

  task automatic build_program();
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      r;
    gen_addr  = BOOT_ADDR;
    prog_len  = 0;
    n_unknown = 0;
    for (int i = 1; i < 32; i++)   // lui + addi per register
    begin
      r = next_rand();
      emit({r[31:12], 5'(i), OPC_LUI});
      r = next_rand();
      emit({r[11:0], 5'(i), 3'd0, 5'(i), OPC_OPIMM});
    end
    while (prog_len - n_unknown < N_KEPT)
    begin
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      r   = next_rand();
      f3  = r[14:12];
      case (rand_below(5))
        0: emit({r[31:12], rd, OPC_LUI});
        1:
        begin
          if (f3 == 3'd1)
            r[31:25] = 7'h00;                   // slli
          else if (f3 == 3'd5)
            r[31:25] = {1'b0, r[30], 5'b0};     // srli or srai
          emit({r[31:20], rs1, f3, rd, OPC_OPIMM});
        end
        2:
        begin
          f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
          emit({f7, rs2, rs1, f3, rd, OPC_OP});
        end
        3:
        begin
          f3[1:0] = 2'(rand_below(3));
          f3[2]   = (f3[1:0] != 2'd2) && r[14];  // lbu or lhu
          emit({r[31:20], rs1, f3, rd, OPC_LOAD});
        end
        default:
        begin
          f3 = 3'(rand_below(3));
          emit({r[31:25], rs2, rs1, f3, r[11:7], OPC_STORE});
        end
      endcase
      if (imem[gen_addr - 4][6:0] != OPC_STORE)
        emit_observe(rd);
      if (rand_below(40) == 0)
      begin
        r = next_rand();
        case (rand_below(4))
          0:       emit({r[31:7], 7'b1100011});  // branch
          1:       emit({r[31:7], 7'b1101111});  // jal
          2:       emit({r[31:7], 7'b0010111});  // auipc
          default: emit({r[31:7], 7'b1110011});  // system
        endcase
        n_unknown++;
        emit_observe(r[11:7]);  // rd field must be untouched
      end
    end
    end_addr = gen_addr;
  endtask

  //////////////////////////////////////////////////
  // isa reference model
  //////////////////////////////////////////////////
  task automatic set_access(input logic we, input word_t ea, input logic [1:0] size,
                            input word_t data);
    word_t w;
    int    nbytes;
    int    first;
    nbytes      = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    first       = int'(ea[1:0]) / nbytes * nbytes;  // offset bits below the size drop out
    acc_pending = 1'b1;
    acc_we      = we;
    acc_addr    = {ea[31:2], 2'b00};
    for (int i = 0; i < 4; i++)
    begin
      acc_be[i]           = (i >= first) && (i < first + nbytes);
      acc_wdata[8*i +: 8] = data[8*(i % nbytes) +: 8];  // low bytes repeat across lanes
    end
    if (we)
    begin
      w = dmem_read(acc_addr);
      for (int i = 0; i < 4; i++)
        if (acc_be[i])
          w[8*i +: 8] = acc_wdata[8*i +: 8];
      dmem[acc_addr] = w;
    end
  endtask

  task automatic model_step(input word_t ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  rd;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      res;
    word_t      w;
    word_t      ea;
    logic [4:0] sh;
    logic       wr;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    a   = regs[ins[19:15]];
    b   = regs[ins[24:20]];
    imm = {{20{ins[31]}}, ins[31:20]};
    sh  = ins[24:20];
    res = '0;
    wr  = 1'b0;
    model_pc = model_pc + 4;
    case (opc)
      OPC_LUI:
      begin
        res = {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      OPC_OPIMM, OPC_OP:
      begin
        if (opc == OPC_OP)
        begin
          imm = b;                   // register form uses rs2
          sh  = b[4:0];
          wr  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        else
          wr = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
        case (f3)
          3'd0: res = (opc == OPC_OP && f7[5]) ? a - imm : a + imm;
          3'd1: res = a << sh;
          3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'd3: res = (a < imm) ? 32'd1 : 32'd0;
          3'd4: res = a ^ imm;
          3'd5:
            if (f7[5])
              res = $signed(a) >>> sh;
            else
              res = a >> sh;
          3'd6: res = a | imm;
          default: res = a & imm;
        endcase
      end
      OPC_LOAD:
        if (f3 != 3'd3 && f3 < 3'd6)
        begin
          ea = a + imm;
          w  = dmem_read({ea[31:2], 2'b00});
          set_access(1'b0, ea, f3[1:0], b);
          if (f3[1:0] == 2'd0)
          begin
            w   = w >> (8 * ea[1:0]);
            res = f3[2] ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
          end
          else if (f3[1:0] == 2'd1)
          begin
            w   = w >> (16 * ea[1]);
            res = f3[2] ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
          end
          else
            res = w;
          wr = 1'b1;
        end
      OPC_STORE:
        if (f3 < 3'd3)
        begin
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          set_access(1'b1, ea, f3[1:0], b);
        end
      default: ;  // dropped opcodes do nothing
    endcase
    if (wr && rd != 5'd0)
      regs[rd] = res;
  endtask

  //////////////////////////////////////////////////
  // memory port responders
  //////////////////////////////////////////////////
  task automatic serve_fetch();
    word_t addr;
    int    d;
    addr = model_pc;
    d    = rand_below(4);
    repeat (d)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      if (!instr_req_o)
        stop_run("instruction request dropped before its grant");
      check_word("held fetch address", instr_addr_o, addr);
    end
    instr_grant_i = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    instr_grant_i = 1'b0;
    if (instr_req_o)
      stop_run("instruction request still active after its grant");
    model_step(imem[addr]);
    d = rand_below(4);
    repeat (d)
    begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    instr_rdata_i  = imem[addr];
    instr_rvalid_i = 1'b1;
    last_valid_cyc = cycle_cnt;
  endtask

  task automatic data_req_matches();
    if (!data_req_o)
      stop_run("data request dropped before its grant");
    check_word("data address", data_addr_o, acc_addr);
    check_bit("data write enable", data_we_o, acc_we);
    check_be("data byte enables", data_be_o, acc_be);
    if (acc_we)
      check_word("store data", data_wdata_o, acc_wdata);
  endtask

  task automatic serve_data();
    int d;
    if (!acc_pending)
      stop_run("data request seen without a pending load or store");
    data_req_matches();
    d = rand_below(4);
    repeat (d)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      data_req_matches();   // payload held until grant
    end
    data_gnt_i = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    data_gnt_i = 1'b0;
    if (data_req_o)
      stop_run("data request still active after its grant");
    d = rand_below(4);
    repeat (d)
    begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    data_rdata_i   = acc_we ? next_rand() : dmem_read(acc_addr);
    data_r_valid_i = 1'b1;
    last_valid_cyc = cycle_cnt;
    acc_pending    = 1'b0;
  endtask

  // ports never busy together with one item in flight
  always @(negedge clk)
    if (rst_n && instr_req_o && data_req_o)
      stop_run("instruction and data requests were active in the same cycle");

  initial
  begin : watchdog
    wait (prog_len > 0);
    #((prog_len * CYC_BUDGET + 50) * 2 * CLK_HALF);
    stop_run("timeout, the core did not reach the end of the program in time");
  end

  initial
  begin : main_seq
    bit finished;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_rdata_i  = '0;
    instr_grant_i  = 1'b0;
    instr_rvalid_i = 1'b0;
    data_rdata_i   = '0;
    data_gnt_i     = 1'b0;
    data_r_valid_i = 1'b0;
    rng_state      = 32'h78dae4be;
    acc_pending    = 1'b0;
    model_pc       = BOOT_ADDR;
    finished       = 1'b0;
    foreach (regs[i])
      regs[i] = '0;
    build_program();
    repeat (3) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;
    repeat (10)   // core stays quiet while enable is low
    begin
      @(posedge clk);
      #DRIVE_DLY;
      if (instr_req_o || core_busy_o)
        stop_run("core became active while fetch enable was low");
    end
    fetch_enable_i = 1'b1;
    last_valid_cyc = cycle_cnt;   // idle and fetch start come before the request
    while (!finished)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      instr_rvalid_i = 1'b0;
      data_r_valid_i = 1'b0;
      if (instr_req_o)
      begin
        check_word("fetch address", instr_addr_o, model_pc);
        check_bit("core busy", core_busy_o, 1'b1);
        request_spacing("instruction request");
        if (acc_pending)
          stop_run("memory instruction ended without its data access");
        if (model_pc == end_addr)
          finished = 1'b1;   // all earlier instructions retired
        else
          serve_fetch();
      end
      else if (data_req_o)
      begin
        check_bit("core busy", core_busy_o, 1'b1);
        request_spacing("data request");
        serve_data();
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- riscv_core.f
riscv_pkg.sv
riscv_fetch.sv
riscv_decoder.sv
riscv_regfile.sv
riscv_alu.sv
riscv_controller.sv
riscv_lsu.sv
riscv_core.sv
tb_riscv_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_riscv_core
FILELIST   := riscv_core.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "simulation FAILED, no pass report"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
